//--- Makefile
# Verilator build and run for the VGA display testbench

LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert -Wno-fatal --top-module VgaDisplayTb -f filelist.f

run: compile
	./obj_dir/VVgaDisplayTb +verilator+error+limit+1000 | tee $(LOG)
	grep -q "sim passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- filelist.f
src/VgaPkg.sv
src/FrameBuffer.sv
src/FrameWriter.sv
src/VgaScanner.sv
src/VgaDisplay.sv
testbench/VgaScanner_props.sv
testbench/VgaDisplayTb.sv

//--- src/FrameBuffer.sv
// Paged monochrome frame buffer, written by the host writer and read by both the writer and the scanner
`timescale 1ns/1ps

module FrameBuffer import VgaPkg::*; (
	input  logic                 Clock,

	input  logic                 WrEn_i,
	input  logic [AddrWidth-1:0] WrAddr_i,
	input  logic [7:0]           WrData_i,

	input  logic [AddrWidth-1:0] HostAddr_i,
	output logic [7:0]           HostData_o,

	input  logic [AddrWidth-1:0] ScanAddr_i,
	output logic [7:0]           ScanData_o
);

	logic [7:0] Memory [BufferDepth];	// One byte per 8 stacked pixels

	always_ff @(posedge Clock) begin
		if (WrEn_i)
			Memory[WrAddr_i] <= WrData_i;
	end

	// Both reads are combinational, so a read sees the contents before this edge's write
	assign HostData_o = Memory[HostAddr_i];
	assign ScanData_o = Memory[ScanAddr_i];

endmodule

//--- src/FrameWriter.sv
// Turns host commands into frame buffer writes, with read-modify-write for pixels and a sequenced fill
`timescale 1ns/1ps

module FrameWriter import VgaPkg::*; (
	input  logic                 Clock,
	input  logic                 Reset,

	input  logic                 CmdValid_i,
	input  HostOp                CmdOp_i,
	input  logic [6:0]           CmdX_i,
	input  logic [6:0]           CmdY_i,
	input  logic [7:0]           CmdData_i,
	output logic                 Busy_o,

	output logic                 WrEn_o,
	output logic [AddrWidth-1:0] WrAddr_o,
	output logic [7:0]           WrData_o,

	output logic [AddrWidth-1:0] HostAddr_o,
	input  logic [7:0]           HostData_i
);

	typedef enum logic {
		WriterIdle,
		WriterFill
	} WriterState;

	WriterState           State;
	logic [AddrWidth-1:0] FillAddr;
	logic [7:0]           FillPattern;

	logic                 Accept;
	logic                 InRange;
	logic                 FillDone;
	logic [7:0]           PixelMask;

	assign Accept   = CmdValid_i && (State == WriterIdle);	// Strobes while busy are lost
	assign InRange  = (CmdY_i < ScreenHeight);
	assign FillDone = (FillAddr == AddrWidth'(BufferDepth - 1));

	assign PixelMask  = 8'd1 << CmdY_i[2:0];
	assign HostAddr_o = {CmdY_i[6:3], CmdX_i};	// Byte under change
	assign Busy_o     = (State == WriterFill);

	always_ff @(posedge Clock or negedge Reset) begin
		if (!Reset) begin
			State    <= WriterIdle;
			FillAddr <= '0;
		end else begin
			case (State)
				WriterIdle: begin
					if (Accept && CmdOp_i == OpFill) begin
						State    <= WriterFill;
						FillAddr <= '0;
					end
				end
				WriterFill: begin
					FillAddr <= FillAddr + 1'b1;
					if (FillDone)
						State <= WriterIdle;
				end
				default: State <= WriterIdle;
			endcase
		end
	end

	// Fill pattern, latched with the fill command
	always_ff @(posedge Clock) begin
		if (Accept && CmdOp_i == OpFill)
			FillPattern <= CmdData_i;
	end

	// Write port, either the fill sweep or one decoded command
	always_comb begin
		WrEn_o   = 1'b0;
		WrAddr_o = HostAddr_o;
		WrData_o = CmdData_i;
		if (State == WriterFill) begin
			WrEn_o   = 1'b1;
			WrAddr_o = FillAddr;
			WrData_o = FillPattern;
		end else if (Accept && InRange) begin
			case (CmdOp_i)
				OpWriteByte: begin
					WrEn_o   = 1'b1;
					WrData_o = CmdData_i;
				end
				OpSetPixel: begin
					WrEn_o   = 1'b1;
					WrData_o = HostData_i | PixelMask;
				end
				OpClearPixel: begin
					WrEn_o   = 1'b1;
					WrData_o = HostData_i & ~PixelMask;
				end
				default: WrEn_o = 1'b0;	// Fill starts next cycle
			endcase
		end
	end

endmodule

//--- src/VgaDisplay.sv
// Top level of the 128x96 monochrome VGA display, joining host writer, frame buffer and scanner
`timescale 1ns/1ps

module VgaDisplay import VgaPkg::*; (
	input  logic       Clock,		// 25 MHz pixel clock
	input  logic       Reset,

	input  logic       CmdValid_i,
	input  HostOp      CmdOp_i,
	input  logic [6:0] CmdX_i,
	input  logic [6:0] CmdY_i,
	input  logic [7:0] CmdData_i,
	output logic       Busy_o,

	output logic       Red_o,
	output logic       Green_o,
	output logic       Blue_o,
	output logic       HSync_o,
	output logic       VSync_o
);

	logic                 WrEn;
	logic [AddrWidth-1:0] WrAddr;
	logic [7:0]           WrData;
	logic [AddrWidth-1:0] HostAddr;
	logic [7:0]           HostData;
	logic [AddrWidth-1:0] ScanAddr;
	logic [7:0]           ScanData;

	FrameWriter u_frameWriter (
		.Clock      (Clock),
		.Reset      (Reset),
		.CmdValid_i (CmdValid_i),
		.CmdOp_i    (CmdOp_i),
		.CmdX_i     (CmdX_i),
		.CmdY_i     (CmdY_i),
		.CmdData_i  (CmdData_i),
		.Busy_o     (Busy_o),
		.WrEn_o     (WrEn),
		.WrAddr_o   (WrAddr),
		.WrData_o   (WrData),
		.HostAddr_o (HostAddr),
		.HostData_i (HostData)
	);

	FrameBuffer u_frameBuffer (
		.Clock      (Clock),
		.WrEn_i     (WrEn),
		.WrAddr_i   (WrAddr),
		.WrData_i   (WrData),
		.HostAddr_i (HostAddr),
		.HostData_o (HostData),
		.ScanAddr_i (ScanAddr),
		.ScanData_o (ScanData)
	);

	VgaScanner u_vgaScanner (
		.Clock      (Clock),
		.Reset      (Reset),
		.ScanAddr_o (ScanAddr),
		.ScanData_i (ScanData),
		.Red_o      (Red_o),
		.Green_o    (Green_o),
		.Blue_o     (Blue_o),
		.HSync_o    (HSync_o),
		.VSync_o    (VSync_o)
	);

endmodule

//--- src/VgaPkg.sv
// Shared VGA timing, frame buffer geometry and host command codes, imported by the design and testbench
package VgaPkg;

	// 640x480 at 60 Hz, counted in pixel clocks and lines
	localparam logic [9:0] HTotal = 10'd800;
	localparam logic [9:0] VTotal = 10'd525;

	localparam logic [9:0] HActive = 10'd640;
	localparam logic [9:0] VActive = 10'd480;

	localparam logic [9:0] HSyncStart = 10'd656;
	localparam logic [9:0] HSyncEnd   = 10'd751;	// Inclusive

	localparam logic [9:0] VSyncStart = 10'd490;
	localparam logic [9:0] VSyncEnd   = 10'd491;	// Inclusive

	// Each screen pixel covers a 5x5 block of VGA pixels
	localparam logic [2:0] PixelScale = 3'd5;

	localparam logic [7:0] ScreenWidth  = 8'd128;
	localparam logic [6:0] ScreenHeight = 7'd96;

	// Byte address is {page[3:0], column[6:0]}
	localparam int AddrWidth   = 11;
	localparam int BufferDepth = 2048;

	// Host command codes
	typedef enum logic [1:0] {
		OpWriteByte  = 2'd0,
		OpSetPixel   = 2'd1,
		OpClearPixel = 2'd2,
		OpFill       = 2'd3
	} HostOp;

endpackage

//--- src/VgaScanner.sv
// Sweeps the 640x480 VGA frame, fetches frame buffer bytes and drives registered sync and colour
`timescale 1ns/1ps

module VgaScanner import VgaPkg::*; (
	input  logic                 Clock,
	input  logic                 Reset,

	output logic [AddrWidth-1:0] ScanAddr_o,
	input  logic [7:0]           ScanData_i,

	output logic                 Red_o,
	output logic                 Green_o,
	output logic                 Blue_o,
	output logic                 HSync_o,
	output logic                 VSync_o
);

	logic [9:0] HCounter;	// 0 to 799
	logic [9:0] VCounter;	// 0 to 524

	logic [2:0] HDivider;	// 0 to 4
	logic [2:0] VDivider;
	logic [6:0] HPixel;		// Column, meaningful below 128
	logic [6:0] VPixel;		// Row, meaningful below 96

	logic       LineEnd;
	logic       FrameEnd;
	logic [3:0] PageNumber;
	logic [2:0] LineInPage;
	logic       ActiveArea;
	logic       PixelBit;

	assign LineEnd  = (HCounter == HTotal - 10'd1);
	assign FrameEnd = LineEnd && (VCounter == VTotal - 10'd1);

	// Beam position
	always_ff @(posedge Clock or negedge Reset) begin
		if (!Reset) begin
			HCounter <= '0;
			VCounter <= '0;
		end else if (!LineEnd) begin
			HCounter <= HCounter + 10'd1;
		end else begin
			HCounter <= '0;
			if (FrameEnd)
				VCounter <= '0;
			else
				VCounter <= VCounter + 10'd1;
		end
	end

	// Screen pixel position, advanced once every five clocks and lines
	always_ff @(posedge Clock or negedge Reset) begin
		if (!Reset) begin
			HDivider <= '0;
			VDivider <= '0;
			HPixel   <= '0;
			VPixel   <= '0;
		end else if (LineEnd) begin
			HDivider <= '0;
			HPixel   <= '0;
			if (FrameEnd) begin
				VDivider <= '0;
				VPixel   <= '0;
			end else if (VDivider == PixelScale - 3'd1) begin
				VDivider <= '0;
				VPixel   <= VPixel + 7'd1;
			end else begin
				VDivider <= VDivider + 3'd1;
			end
		end else if (HDivider == PixelScale - 3'd1) begin
			HDivider <= '0;
			HPixel   <= HPixel + 7'd1;	// Wraps in the blanking, never displayed
		end else begin
			HDivider <= HDivider + 3'd1;
		end
	end

	assign PageNumber = VPixel[6:3];
	assign LineInPage = VPixel[2:0];
	assign ScanAddr_o = {PageNumber, HPixel};

	assign ActiveArea = (HCounter < HActive) && (VCounter < VActive);
	assign PixelBit   = ActiveArea && ScanData_i[LineInPage];

	// Output stage, one clock behind the counters
	always_ff @(posedge Clock or negedge Reset) begin
		if (!Reset) begin
			HSync_o <= 1'b1;
			VSync_o <= 1'b1;
			Red_o   <= 1'b0;
			Green_o <= 1'b0;
			Blue_o  <= 1'b0;
		end else begin
			HSync_o <= !((HCounter >= HSyncStart) && (HCounter <= HSyncEnd));	// Active low
			VSync_o <= !((VCounter >= VSyncStart) && (VCounter <= VSyncEnd));
			Red_o   <= PixelBit;	// Monochrome, all three follow
			Green_o <= PixelBit;
			Blue_o  <= PixelBit;
		end
	end

endmodule

//--- testbench/VgaDisplayTb.sv
// Self-checking testbench for the VGA display, drives random host commands and checks every output cycle
`timescale 1ns/1ps

module VgaDisplayTb import VgaPkg::*; ();

	localparam int HTot = 800;
	localparam int VTot = 525;
	localparam int HAct = 640;
	localparam int VAct = 480;
	localparam int TimeoutCycles = 3000000;	// Seven ends of active video, about 2.9 million clocks
	localparam int ErrorPrintLimit = 30;

	logic       Clock;
	logic       Reset;
	logic       CmdValid;
	HostOp      CmdOp;
	logic [6:0] CmdX;
	logic [6:0] CmdY;
	logic [7:0] CmdData;
	logic       Busy;
	logic       Red;
	logic       Green;
	logic       Blue;
	logic       HSync;
	logic       VSync;

	logic [31:0] LfsrState;

	// Reference model of the buffer and the beam
	logic [7:0]  Model [2048];
	logic        ModelBusy;
	logic [10:0] ModelFillAddr;
	logic [7:0]  ModelFillData;
	int          MonH;
	int          MonV;
	int          ActiveEnds;	// Bumped when the last active line finishes

	logic ExpHSync;
	logic ExpVSync;
	logic ExpColour;
	logic ExpBusy;
	logic ExpActive;
	logic CheckColour;	// Buffer holds known data

	int Cycles;
	int Checks;
	int Errors;
	int TestsRun;
	int TestsFailed;

	VgaDisplay u_VgaDisplay (
		.Clock      (Clock),
		.Reset      (Reset),
		.CmdValid_i (CmdValid),
		.CmdOp_i    (CmdOp),
		.CmdX_i     (CmdX),
		.CmdY_i     (CmdY),
		.CmdData_i  (CmdData),
		.Busy_o     (Busy),
		.Red_o      (Red),
		.Green_o    (Green),
		.Blue_o     (Blue),
		.HSync_o    (HSync),
		.VSync_o    (VSync)
	);

	always #20 Clock = ~Clock;

	// Taps 32, 22, 2, 1
	function automatic logic LfsrStep();
		logic Feedback;
		Feedback = LfsrState[31] ^ LfsrState[21] ^ LfsrState[1] ^ LfsrState[0];
		LfsrState = {LfsrState[30:0], Feedback};
		return Feedback;
	endfunction

	function automatic logic [31:0] RandomBits(input int Count);
		logic [31:0] Value;
		Value = '0;
		for (int i = 0; i < Count; i++)
			Value = {Value[30:0], LfsrStep()};
		return Value;
	endfunction

	function automatic logic [6:0] RandomRow();
		return 7'(RandomBits(7) % 96);
	endfunction

	// Byte {v/40, h/5}, bit v/5 mod 8, dark outside the active window
	function automatic logic ExpectedPixel(input int H, input int V);
		logic [10:0] Addr;
		logic [2:0]  Bit;
		if (H >= HAct || V >= VAct)
			return 1'b0;
		Addr = 11'((V / 40) * 128 + H / 5);
		Bit  = 3'((V / 5) % 8);
		return Model[Addr][Bit];
	endfunction

	task automatic UpdateModel();
		logic [10:0] Addr;
		logic [7:0]  Mask;
		Addr = {CmdY[6:3], CmdX};
		Mask = 8'd1 << CmdY[2:0];
		if (ModelBusy) begin
			Model[ModelFillAddr] = ModelFillData;	// Commands ignored meanwhile
			if (ModelFillAddr == 11'd2047)
				ModelBusy = 1'b0;
			ModelFillAddr = ModelFillAddr + 11'd1;
		end else if (CmdValid) begin
			if (CmdOp == OpFill) begin
				ModelBusy     = 1'b1;
				ModelFillAddr = '0;
				ModelFillData = CmdData;
			end else if (CmdY < 7'd96) begin
				case (CmdOp)
					OpWriteByte:  Model[Addr] = CmdData;
					OpSetPixel:   Model[Addr] = Model[Addr] | Mask;
					OpClearPixel: Model[Addr] = Model[Addr] & ~Mask;
					default:      Model[Addr] = Model[Addr];
				endcase
			end
		end
	endtask

	task automatic Compare(input string What, input logic [31:0] Got, input logic [31:0] Expected);
		Checks++;
		if (Got !== Expected) begin
			Errors++;
			if (Errors <= ErrorPrintLimit)
				$display("[ERROR] %0d ns: %s, expected %0h, got %0h", $time, What, Expected, Got);
		end
	endtask

	// Expected outputs after this edge, taken from the model before its write
	always @(posedge Clock) begin
		if (!Reset) begin
			MonH      = 0;
			MonV      = 0;
			ModelBusy = 1'b0;
			ExpHSync  = 1'b1;
			ExpVSync  = 1'b1;
			ExpColour = 1'b0;
			ExpBusy   = 1'b0;
			ExpActive = 1'b0;
		end else begin
			ExpActive = (MonH < HAct) && (MonV < VAct);
			ExpColour = ExpectedPixel(MonH, MonV);
			ExpHSync  = !(MonH >= 656 && MonH <= 751);
			ExpVSync  = !(MonV >= 490 && MonV <= 491);
			if (MonV == VAct - 1 && MonH == HTot - 1)
				ActiveEnds++;
			if (MonH == HTot - 1) begin
				MonH = 0;
				MonV = (MonV == VTot - 1) ? 0 : MonV + 1;
			end else begin
				MonH = MonH + 1;
			end
			UpdateModel();
			ExpBusy = ModelBusy;
		end
	end

	always @(negedge Clock) begin
		Compare("HSync_o", 32'(HSync), 32'(ExpHSync));
		Compare("VSync_o", 32'(VSync), 32'(ExpVSync));
		Compare("Busy_o", 32'(Busy), 32'(ExpBusy));
		if (CheckColour || !ExpActive) begin
			Compare("Red_o", 32'(Red), 32'(ExpColour));
			Compare("Green_o", 32'(Green), 32'(ExpColour));
			Compare("Blue_o", 32'(Blue), 32'(ExpColour));
		end
	end

	always @(posedge Clock) begin
		Cycles++;
		if (Cycles >= TimeoutCycles) begin
			$display("Timeout, the tests did not finish within %0d clock cycles", TimeoutCycles);
			$display("sim failed");
			$finish;
		end
	end

	// Called on a falling edge, returns on the next one with the strobe dropped
	task automatic SendCmd(input HostOp Op, input logic [6:0] X, input logic [6:0] Y,
			input logic [7:0] Data);
		CmdValid = 1'b1;
		CmdOp    = Op;
		CmdX     = X;
		CmdY     = Y;
		CmdData  = Data;
		@(negedge Clock);
		CmdValid = 1'b0;
	endtask

	task automatic WaitFrame();
		int Start;
		Start = ActiveEnds;
		while (ActiveEnds == Start)
			@(negedge Clock);
	endtask

	// Rows 96 and up map to pages 12 to 15, which the scanner never shows
	task automatic CompareHiddenPages();
		for (int Addr = 1536; Addr < 2048; Addr++)
			Compare("hidden page byte", 32'(u_VgaDisplay.u_frameBuffer.Memory[Addr]),
				32'(Model[Addr]));
	endtask

	task automatic ReportTest(input string Name, input int ErrorsBefore);
		TestsRun++;
		if (Errors != ErrorsBefore)
			TestsFailed++;
		$display("Test %0d %s: %0d mismatches", TestsRun, Name, Errors - ErrorsBefore);
	endtask

	task automatic BlankFrameTest();
		int Before;
		Before = Errors;
		WaitFrame();	// Into the first vertical blanking
		SendCmd(OpFill, 7'd0, 7'd0, 8'h00);
		while (Busy)
			@(negedge Clock);
		CheckColour = 1'b1;
		WaitFrame();
		ReportTest("zero fill shows a dark frame", Before);
	endtask

	task automatic ByteWriteTest();
		int Before;
		logic [6:0] X;
		logic [6:0] Y;
		logic [7:0] Data;
		Before = Errors;
		repeat (400) begin
			X    = 7'(RandomBits(7));
			Y    = RandomRow();
			Data = 8'(RandomBits(8));
			SendCmd(OpWriteByte, X, Y, Data);
		end
		WaitFrame();
		ReportTest("random byte writes", Before);
	endtask

	task automatic PixelOpTest();
		int Before;
		logic [6:0] X;
		logic [6:0] Y;
		HostOp Op;
		Before = Errors;
		for (int Addr = 0; Addr < 1536; Addr++)
			SendCmd(OpWriteByte, 7'(Addr % 128), {4'(Addr / 128), 3'b000}, 8'(RandomBits(8)));
		repeat (600) begin
			Op = RandomBits(1) ? OpSetPixel : OpClearPixel;
			X  = 7'(RandomBits(7));
			Y  = RandomRow();
			SendCmd(Op, X, Y, 8'(RandomBits(8)));
		end
		WaitFrame();
		ReportTest("set and clear pixels", Before);
	endtask

	task automatic FillTest();
		int Before;
		int BusyCycles;
		HostOp Op;
		logic [6:0] X;
		logic [6:0] Y;
		Before = Errors;
		SendCmd(OpFill, 7'd0, 7'd0, 8'(RandomBits(8)));
		BusyCycles = 0;
		while (Busy) begin
			BusyCycles++;
			Op = HostOp'(2'(RandomBits(2)));	// Must all be dropped
			X  = 7'(RandomBits(7));
			Y  = 7'(RandomBits(7));
			SendCmd(Op, X, Y, 8'(RandomBits(8)));
		end
		Compare("fill busy cycles", 32'(BusyCycles), 32'd2048);
		WaitFrame();
		ReportTest("pattern fill", Before);
	endtask

	task automatic OutOfRangeTest();
		int Before;
		HostOp Op;
		logic [6:0] X;
		logic [6:0] Y;
		Before = Errors;
		repeat (300) begin
			Op = HostOp'(2'(RandomBits(2) % 3));
			X  = 7'(RandomBits(7));
			Y  = 7'(96 + RandomBits(5));	// Rows 96 to 127
			SendCmd(Op, X, Y, 8'(RandomBits(8)));
		end
		CompareHiddenPages();
		WaitFrame();
		ReportTest("out of range rows", Before);
	endtask

	// Rewrites the very byte the scanner reads on the same edge
	task automatic BeamWriteTest();
		int Before;
		Before = Errors;
		while (MonV >= VAct)
			@(negedge Clock);
		repeat (16000) begin
			if (MonH < HAct && MonV < VAct)
				SendCmd(OpWriteByte, 7'(MonH / 5), 7'(MonV / 5), 8'(RandomBits(8)));
			else
				@(negedge Clock);
		end
		WaitFrame();
		ReportTest("writes during active video", Before);
	endtask

	initial begin
		LfsrState   = 32'hec3d6cb6;
		Clock       = 1'b0;
		Reset       = 1'b0;
		CmdValid    = 1'b0;
		CmdOp       = OpWriteByte;
		CmdX        = '0;
		CmdY        = '0;
		CmdData     = '0;
		CheckColour = 1'b0;
		repeat (8) @(negedge Clock);
		Reset = 1'b1;
		BlankFrameTest();
		ByteWriteTest();
		PixelOpTest();
		FillTest();
		OutOfRangeTest();
		BeamWriteTest();
		$display("%0d tests, %0d failed, %0d checks, %0d mismatches, %0d assertion failures",
			TestsRun, TestsFailed, Checks, Errors, u_VgaDisplay.u_vgaScanner.u_scannerProps.Failures);
		if (Errors == 0 && TestsFailed == 0 &&
				u_VgaDisplay.u_vgaScanner.u_scannerProps.Failures == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

//--- testbench/VgaScanner_props.sv
// Concurrent checks on the scanner's sync pulses and blanking, bound into the VgaScanner module
`timescale 1ns/1ps

module VgaScannerProps import VgaPkg::*; (
	input logic       Clock,
	input logic       Reset,
	input logic [9:0] HCounter_i,
	input logic [9:0] VCounter_i,
	input logic       HSync_i,
	input logic       VSync_i,
	input logic       Red_i,
	input logic       Green_i,
	input logic       Blue_i
);

	int         Failures;	// Summed up by the testbench
	logic [7:0] HSyncLow;	// Length of the current sync pulse

	always_ff @(posedge Clock or negedge Reset) begin
		if (!Reset)
			HSyncLow <= '0;
		else if (!HSync_i)
			HSyncLow <= HSyncLow + 8'd1;
		else
			HSyncLow <= '0;
	end

	HSyncWidth: assert property (@(posedge Clock) disable iff (!Reset)
		$rose(HSync_i) |-> HSyncLow == 8'd96)
		else begin
			Failures++;
			$error("HSync pulse lasted %0d cycles instead of 96", HSyncLow);
		end

	// Outputs lag the counters by one clock
	VSyncLines: assert property (@(posedge Clock) disable iff (!Reset)
		!VSync_i |-> ($past(VCounter_i) >= VSyncStart && $past(VCounter_i) <= VSyncEnd))
		else begin
			Failures++;
			$error("VSync low outside lines 490 to 491");
		end

	BlankColour: assert property (@(posedge Clock) disable iff (!Reset)
		$past(HCounter_i) >= HActive |-> !(Red_i || Green_i || Blue_i))
		else begin
			Failures++;
			$error("Colour lit during horizontal blanking");
		end

	HCounterRange: assert property (@(posedge Clock) disable iff (!Reset)
		HCounter_i <= HTotal - 10'd1)
		else begin
			Failures++;
			$error("HCounter went past 799");
		end

endmodule

bind VgaScanner VgaScannerProps u_scannerProps (
	.Clock      (Clock),
	.Reset      (Reset),
	.HCounter_i (HCounter),
	.VCounter_i (VCounter),
	.HSync_i    (HSync_o),
	.VSync_i    (VSync_o),
	.Red_i      (Red_o),
	.Green_i    (Green_o),
	.Blue_i     (Blue_o)
);
